// File: rtl/qe_reg_pkg.sv
/*
 * Quadrature encoder register map
 * Word offsets of the channel registers and the layout of the
 * configuration word
 */

package qe_reg_pkg;

   // word offsets from the channel base address
   parameter logic [7:0] reg_count_off      = 8'd0;
   parameter logic [7:0] reg_turns_off      = 8'd1;
   parameter logic [7:0] reg_speed_off      = 8'd2;
   parameter logic [7:0] reg_phase_time_off = 8'd3;
   parameter logic [7:0] reg_cpr_off        = 8'd4;
   parameter logic [7:0] reg_config_off     = 8'd5;
   parameter logic [7:0] reg_status_off     = 8'd6;

   parameter int num_qe_regs = 7;

   // configuration fields, bit 0 upwards
   typedef struct packed {
      logic [22:0] reserved;
      logic [2:0]  filter_size;
      logic        filter_enable;
      logic        speed_enable;
      logic        flip_ab;
      logic        sim_direction;
      logic        sim_enable;
      logic        source;
   } qe_config_t;

   // raw view for the bus, field view for the channel logic
   typedef union packed {
      logic [31:0] raw;
      qe_config_t  fields;
   } qe_config_u;

endpackage

// File: rtl/qe_enc_pkg.sv
/*
 * Quadrature encoder signal types
 * Direction and source encodings, speed filter size and speed clamp
 */

package qe_enc_pkg;

   typedef enum logic {
      dir_cw  = 1'b0,
      dir_ccw = 1'b1
   } qe_dir_e;

   typedef enum logic {
      src_external = 1'b0,
      src_internal = 1'b1
   } qe_source_e;

   // 0..4 select 1..16 samples, anything larger acts as 0
   typedef logic [2:0] filter_size_t;

   // longest A-high period reported, in clock cycles
   parameter logic [31:0] max_speed_count = 32'd1_000_000;

endpackage

// File: rtl/qe_event_if.sv
/*
 * Decoded motion events
 * Carries count pulses, direction, index edges and the A level
 */

`timescale 1ns/1ns

interface qe_event_if import qe_enc_pkg::*; ();

   logic    count_pulse;
   qe_dir_e direction;
   logic    index_rise;
   logic    a_level;

   modport source (output count_pulse, output direction, output index_rise, output a_level);

   modport sink (input count_pulse, input direction, input index_rise, input a_level);

endinterface

// File: rtl/qe_reg_file.sv
/*
 * Encoder channel register file
 * One-word request/acknowledge bus slave with the writable
 * configuration registers and readback of the measured values
 */

`timescale 1ns/1ns

module qe_reg_file import qe_reg_pkg::*; #(
   parameter logic [7:0] qe_base = 8'h10
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        reg_req,
   input  logic        reg_write,
   input  logic [7:0]  reg_addr,
   input  logic [31:0] reg_wdata,
   output logic        reg_ack,
   output logic [31:0] reg_rdata,
   input  logic [31:0] count,
   input  logic [31:0] turns,
   input  logic [31:0] speed,
   input  logic [5:0]  status,
   output qe_config_u  cfg,
   output logic [31:0] phase_time,
   output logic [31:0] counts_per_rev
);

   logic [7:0]  offset;
   logic        hit;
   logic        req_seen;
   logic        accept;
   logic [31:0] read_word;

   // offset wraps for addresses below the base, so one compare covers the range
   assign offset = reg_addr - qe_base;
   assign hit    = offset < 8'(num_qe_regs);
   assign accept = reg_req && hit && !req_seen;

   always_comb begin
      case (offset)
         reg_count_off:      read_word = count;
         reg_turns_off:      read_word = turns;
         reg_speed_off:      read_word = speed;
         reg_phase_time_off: read_word = phase_time;
         reg_cpr_off:        read_word = counts_per_rev;
         reg_config_off:     read_word = cfg.raw;
         reg_status_off:     read_word = {26'd0, status};
         default:            read_word = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////
   // handshake and register update

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         reg_ack        <= 1'b0;
         req_seen       <= 1'b0;
         reg_rdata      <= '0;
         cfg.raw        <= '0;
         phase_time     <= '0;
         counts_per_rev <= '0;
      end else begin
         // one ack per request, rearmed once the host drops reg_req
         req_seen <= reg_req;
         reg_ack  <= accept;
         if (accept && !reg_write) begin
            reg_rdata <= read_word;
         end
         if (accept && reg_write) begin
            case (offset)
               reg_phase_time_off: phase_time     <= reg_wdata;
               reg_cpr_off:        counts_per_rev <= reg_wdata;
               reg_config_off:     cfg.raw        <= reg_wdata;
               default:            ;
            endcase
         end
      end
   end

endmodule

// File: rtl/qe_pattern_gen.sv
/*
 * Simulated quadrature encoder
 * Steps A/B through the quadrature states every phase_time cycles
 * and raises I once per revolution
 */

`timescale 1ns/1ns

module qe_pattern_gen import qe_enc_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        enable,
   input  qe_dir_e     direction,
   input  logic [31:0] phase_time,
   input  logic [31:0] counts_per_rev,
   output logic        a,
   output logic        b,
   output logic        i
);

   logic [31:0] phase_timer;
   logic [31:0] phase_limit;
   logic [31:0] cycle_count;
   logic [1:0]  phase;
   logic [1:0]  next_phase;
   logic        step;

   // zero phase time runs at one step per cycle
   assign phase_limit = (phase_time == '0) ? 32'd1 : phase_time;
   assign step        = enable && (phase_timer >= phase_limit - 32'd1);
   assign next_phase  = (direction == dir_cw) ? phase + 2'd1 : phase - 2'd1;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         phase_timer <= '0;
         phase       <= 2'd0;
         cycle_count <= '0;
         i           <= 1'b0;
      end else if (step) begin
         phase_timer <= '0;
         phase       <= next_phase;
         if (next_phase == 2'd0) begin
            // back at 00, one full cycle done
            if (cycle_count + 32'd1 >= counts_per_rev) begin
               cycle_count <= '0;
               i           <= 1'b1;
            end else begin
               cycle_count <= cycle_count + 32'd1;
               i           <= 1'b0;
            end
         end else begin
            i <= 1'b0;
         end
      end else if (enable) begin
         phase_timer <= phase_timer + 32'd1;
      end
   end

   // phase 0..3 maps to (A,B) = 00, 10, 11, 01
   assign a = (phase == 2'd1) || (phase == 2'd2);
   assign b = phase[1];

endmodule

// File: rtl/qe_input_select.sv
/*
 * Encoder input selection
 * Synchronizes the external pins, picks external or simulated
 * signals and optionally swaps A and B
 */

`timescale 1ns/1ns

module qe_input_select import qe_enc_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       ext_a_async,
   input  logic       ext_b_async,
   input  logic       ext_i_async,
   input  logic       int_a,
   input  logic       int_b,
   input  logic       int_i,
   input  qe_source_e source,
   input  logic       flip_ab,
   output logic       a,
   output logic       b,
   output logic       i,
   output logic [2:0] ext_sync
);

   // bit order {i, b, a} in both stages
   logic [2:0] sync_meta;
   logic [2:0] src_abi;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         sync_meta <= '0;
         ext_sync  <= '0;
      end else begin
         sync_meta <= {ext_i_async, ext_b_async, ext_a_async};
         ext_sync  <= sync_meta;
      end
   end

   assign src_abi = (source == src_internal) ? {int_i, int_b, int_a} : ext_sync;

   assign a = flip_ab ? src_abi[1] : src_abi[0];
   assign b = flip_ab ? src_abi[0] : src_abi[1];
   assign i = src_abi[2];

endmodule

// File: rtl/qe_decoder.sv
/*
 * 4x quadrature decoder
 * Turns A/B state changes into count pulses with direction and
 * flags rising edges of the index
 */

`timescale 1ns/1ns

module qe_decoder import qe_enc_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       a,
   input  logic       b,
   input  logic       i,
   qe_event_if.source events
);

   logic [1:0] prev_idx;
   logic [1:0] cur_idx;
   logic [1:0] delta;
   logic       prev_i;

   // gray state to position in the clockwise cycle 00, 10, 11, 01
   assign cur_idx = {b, a ^ b};
   assign delta   = cur_idx - prev_idx;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         prev_idx           <= 2'd0;
         prev_i             <= 1'b0;
         events.count_pulse <= 1'b0;
         events.direction   <= dir_cw;
         events.index_rise  <= 1'b0;
         events.a_level     <= 1'b0;
      end else begin
         prev_idx <= cur_idx;
         prev_i   <= i;

         // one step either way counts, a double step is dropped
         events.count_pulse <= (delta == 2'd1) || (delta == 2'd3);
         if (delta == 2'd1) begin
            events.direction <= dir_cw;
         end else if (delta == 2'd3) begin
            events.direction <= dir_ccw;
         end

         events.index_rise <= i && !prev_i;
         events.a_level    <= a;
      end
   end

endmodule

// File: rtl/qe_position_counter.sv
/*
 * Position and turns counters
 * Signed up/down counts of decoded steps and index pulses
 */

`timescale 1ns/1ns

module qe_position_counter import qe_enc_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   qe_event_if.sink    events,
   output logic [31:0] count,
   output logic [31:0] turns
);

   logic [31:0] step;

   // two's complement +1 or -1
   assign step = (events.direction == dir_cw) ? 32'd1 : 32'hFFFF_FFFF;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         count <= '0;
         turns <= '0;
      end else begin
         if (events.count_pulse) begin
            count <= count + step;
         end
         if (events.index_rise) begin
            turns <= turns + step;
         end
      end
   end

endmodule

// File: rtl/qe_speed_measure.sv
/*
 * Speed measurement
 * Times each A-high period in clock cycles, averages over a
 * power-of-two number of samples and clamps the result
 */

`timescale 1ns/1ns

module qe_speed_measure import qe_enc_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   qe_event_if.sink     events,
   input  logic         enable,
   input  logic         filter_enable,
   input  filter_size_t filter_size,
   output logic [31:0]  speed
);

   logic [31:0] period_count;
   logic [35:0] accum;
   logic [35:0] sum;
   logic [35:0] average;
   logic [3:0]  sample_count;
   logic [2:0]  shift;
   logic        a_prev;
   logic        a_fall;
   logic        last_sample;

   // out-of-range sizes fall back to a single sample
   assign shift = (filter_enable && filter_size <= 3'd4) ? filter_size : 3'd0;

   assign a_fall      = a_prev && !events.a_level;
   assign last_sample = ({1'b0, sample_count} + 5'd1) >= (5'd1 << shift);
   assign sum         = accum + 36'(period_count);
   assign average     = sum >> shift;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period_count <= '0;
         accum        <= '0;
         sample_count <= '0;
         a_prev       <= 1'b0;
         speed        <= '0;
      end else if (!enable) begin
         period_count <= '0;
         accum        <= '0;
         sample_count <= '0;
         a_prev       <= 1'b0;
         speed        <= '0;
      end else begin
         a_prev <= events.a_level;
         if (events.a_level) begin
            // saturate on a stalled motor
            if (period_count != '1) begin
               period_count <= period_count + 32'd1;
            end
         end else if (a_fall) begin
            period_count <= '0;
            if (last_sample) begin
               accum        <= '0;
               sample_count <= '0;
               speed        <= (average > 36'(max_speed_count)) ? max_speed_count
                                                               : average[31:0];
            end else begin
               accum        <= sum;
               sample_count <= sample_count + 4'd1;
            end
         end
      end
   end

endmodule

// File: rtl/qe_channel.sv
/*
 * Quadrature encoder channel
 * Register bus slave, encoder source selection, 4x decoding,
 * position, turns and speed measurement for one encoder
 */

`timescale 1ns/1ns

module qe_channel import qe_reg_pkg::*; import qe_enc_pkg::*; #(
   parameter logic [7:0] qe_base = 8'h10
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        reg_req,
   input  logic        reg_write,
   input  logic [7:0]  reg_addr,
   input  logic [31:0] reg_wdata,
   output logic        reg_ack,
   output logic [31:0] reg_rdata,
   input  logic        ext_a,
   input  logic        ext_b,
   input  logic        ext_i
);

   qe_config_u  cfg;
   logic [31:0] phase_time;
   logic [31:0] counts_per_rev;
   logic [31:0] count;
   logic [31:0] turns;
   logic [31:0] speed;
   logic [5:0]  status;
   logic [2:0]  ext_sync;
   logic        int_a;
   logic        int_b;
   logic        int_i;
   logic        sel_a;
   logic        sel_b;
   logic        sel_i;

   qe_event_if events ();

   assign status = {sel_i, sel_b, sel_a, ext_sync};

   ////////////////////////////////////////////////////////////////////
   // host side

   qe_reg_file #(
      .qe_base (qe_base)
   ) reg_file_i (
      .clk            (clk),
      .reset          (reset),
      .reg_req        (reg_req),
      .reg_write      (reg_write),
      .reg_addr       (reg_addr),
      .reg_wdata      (reg_wdata),
      .reg_ack        (reg_ack),
      .reg_rdata      (reg_rdata),
      .count          (count),
      .turns          (turns),
      .speed          (speed),
      .status         (status),
      .cfg            (cfg),
      .phase_time     (phase_time),
      .counts_per_rev (counts_per_rev)
   );

   ////////////////////////////////////////////////////////////////////
   // encoder signal path

   qe_pattern_gen pattern_gen_i (
      .clk            (clk),
      .reset          (reset),
      .enable         (cfg.fields.sim_enable),
      .direction      (qe_dir_e'(cfg.fields.sim_direction)),
      .phase_time     (phase_time),
      .counts_per_rev (counts_per_rev),
      .a              (int_a),
      .b              (int_b),
      .i              (int_i)
   );

   qe_input_select input_select_i (
      .clk         (clk),
      .reset       (reset),
      .ext_a_async (ext_a),
      .ext_b_async (ext_b),
      .ext_i_async (ext_i),
      .int_a       (int_a),
      .int_b       (int_b),
      .int_i       (int_i),
      .source      (qe_source_e'(cfg.fields.source)),
      .flip_ab     (cfg.fields.flip_ab),
      .a           (sel_a),
      .b           (sel_b),
      .i           (sel_i),
      .ext_sync    (ext_sync)
   );

   qe_decoder decoder_i (
      .clk    (clk),
      .reset  (reset),
      .a      (sel_a),
      .b      (sel_b),
      .i      (sel_i),
      .events (events.source)
   );

   ////////////////////////////////////////////////////////////////////
   // measurements

   qe_position_counter position_counter_i (
      .clk    (clk),
      .reset  (reset),
      .events (events.sink),
      .count  (count),
      .turns  (turns)
   );

   qe_speed_measure speed_measure_i (
      .clk           (clk),
      .reset         (reset),
      .events        (events.sink),
      .enable        (cfg.fields.speed_enable),
      .filter_enable (cfg.fields.filter_enable),
      .filter_size   (filter_size_t'(cfg.fields.filter_size)),
      .speed         (speed)
   );

endmodule

// File: dv/qe_channel_tb.sv
/*
 * Quadrature encoder channel testbench
 * Register bus access, an external encoder model and reference
 * checks of count, turns, status, generator and speed
 */

`timescale 1ns/1ns

module qe_channel_tb;

   localparam logic [7:0] base = 8'h10;
   localparam int bus_timeout = 20;
   localparam int step_cycles = 8;

   // register offsets and configuration bits
   localparam logic [7:0] off_count  = 8'd0;
   localparam logic [7:0] off_turns  = 8'd1;
   localparam logic [7:0] off_speed  = 8'd2;
   localparam logic [7:0] off_phase  = 8'd3;
   localparam logic [7:0] off_status = 8'd6;
   localparam logic [7:0] off_cpr    = 8'd4;
   localparam logic [7:0] off_config = 8'd5;
   localparam logic [31:0] cfg_source  = 32'h01;
   localparam logic [31:0] cfg_sim_en  = 32'h02;
   localparam logic [31:0] cfg_sim_ccw = 32'h04;
   localparam logic [31:0] cfg_flip    = 32'h08;
   localparam logic [31:0] cfg_speed   = 32'h10;
   localparam logic [31:0] cfg_filter  = 32'h20;

   // longest reported A-high period
   localparam logic [31:0] speed_clamp = 32'd1_000_000;

   logic        clk;
   logic        reset;
   logic        reg_req;
   logic        reg_write;
   logic [7:0]  reg_addr;
   logic [31:0] reg_wdata;
   logic        reg_ack;
   logic [31:0] reg_rdata;
   logic        ext_a;
   logic        ext_b;
   logic        ext_i;

   int errors;
   int tests_run;
   int tests_failed;
   int enc_phase;
   // 1 and -1 are steps, 2 is an index pulse
   int events_q[$];
   int periods_q[$];

   qe_channel #(
      .qe_base (base)
   ) dut_i (
      .clk       (clk),
      .reset     (reset),
      .reg_req   (reg_req),
      .reg_write (reg_write),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_ack   (reg_ack),
      .reg_rdata (reg_rdata),
      .ext_a     (ext_a),
      .ext_b     (ext_b),
      .ext_i     (ext_i)
   );

   always #2 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // reference model

   function automatic int ref_count();
      int total;
      total = 0;
      for (int k = 0; k < events_q.size(); k++) begin
         if (events_q[k] != 2) begin
            total += events_q[k];
         end
      end
      return total;
   endfunction

   // an index rise counts in the direction of the last step
   function automatic int ref_turns();
      int total;
      int last_dir;
      total = 0;
      last_dir = 1;
      for (int k = 0; k < events_q.size(); k++) begin
         if (events_q[k] == 2) begin
            total += last_dir;
         end else begin
            last_dir = events_q[k];
         end
      end
      return total;
   endfunction

   function automatic logic [31:0] ref_speed(int fs, logic [31:0] limit);
      longint total;
      longint mean;
      total = 0;
      for (int k = 0; k < periods_q.size(); k++) begin
         total += periods_q[k];
      end
      mean = total >> fs;
      if (mean > limit) begin
         return limit;
      end
      return mean[31:0];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // reporting and bus access

   task automatic mismatch(string name, logic [31:0] exp, logic [31:0] act);
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act);
      errors++;
   endtask

   task automatic report_error(string text);
      $display("ERROR %s", text);
      errors++;
   endtask

   task automatic test_done(string name, int errors_before);
      tests_run++;
      if (errors > errors_before) begin
         tests_failed++;
         $display("test %-24s %0d errors", name, errors - errors_before);
      end else begin
         $display("test %-24s ok", name);
      end
   endtask

   task automatic bus_access(input logic write, input logic [7:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic acked);
      int waited;
      @(posedge clk);
      reg_req   <= 1'b1;
      reg_write <= write;
      reg_addr  <= addr;
      reg_wdata <= wdata;
      acked  = 1'b0;
      rdata  = '0;
      waited = 0;
      while (!acked && waited < bus_timeout) begin
         @(posedge clk);
         waited++;
         if (reg_ack) begin
            acked = 1'b1;
            rdata = reg_rdata;
         end
      end
      reg_req <= 1'b0;
   endtask

   task automatic write_reg(logic [7:0] addr, logic [31:0] data);
      logic [31:0] unused;
      logic        acked;
      bus_access(1'b1, addr, data, unused, acked);
      if (!acked) begin
         report_error($sformatf("no acknowledge for write to address 0x%02h", addr));
      end
   endtask

   task automatic read_reg(logic [7:0] addr, output logic [31:0] data);
      logic acked;
      bus_access(1'b0, addr, 32'd0, data, acked);
      if (!acked) begin
         report_error($sformatf("no acknowledge for read of address 0x%02h", addr));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // encoder model, pins change on a clock edge

   task automatic apply_reset();
      @(posedge clk);
      reset   <= 1'b0;
      reg_req <= 1'b0;
      ext_a   <= 1'b0;
      ext_b   <= 1'b0;
      ext_i   <= 1'b0;
      repeat (8) @(posedge clk);
      reset <= 1'b1;
      enc_phase = 0;
   endtask

   // clockwise (A,B) order 00, 10, 11, 01
   task automatic encoder_step(int dir);
      enc_phase = (enc_phase + dir + 4) % 4;
      @(posedge clk);
      ext_a <= (enc_phase == 1) || (enc_phase == 2);
      ext_b <= (enc_phase >= 2);
      repeat (step_cycles) @(posedge clk);
   endtask

   task automatic index_pulse();
      @(posedge clk);
      ext_i <= 1'b1;
      repeat (step_cycles) @(posedge clk);
      ext_i <= 1'b0;
      repeat (step_cycles) @(posedge clk);
   endtask

   task automatic play_events();
      for (int k = 0; k < events_q.size(); k++) begin
         if (events_q[k] == 2) begin
            index_pulse();
         end else begin
            encoder_step(events_q[k]);
         end
      end
   endtask

   task automatic a_high_pulse(int len);
      @(posedge clk);
      ext_a <= 1'b1;
      repeat (len) @(posedge clk);
      ext_a <= 1'b0;
      repeat (6) @(posedge clk);
   endtask

   // speed stays zero until the sample set completes
   task automatic poll_speed(output logic [31:0] value);
      int tries;
      value = '0;
      tries = 0;
      while (value == '0 && tries < 20) begin
         read_reg(base + off_speed, value);
         tries++;
      end
      if (value == '0) begin
         report_error("speed register stayed zero after the last sample");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // test sequence

   initial begin
      logic [31:0] rdata;
      logic [31:0] wval;
      logic [31:0] exp;
      logic [31:0] count_a;
      logic [2:0]  lv;
      logic        acked;
      int          seed_val;
      int          start;
      int          fs;
      int          sc;
      int          n;

      clk       = 1'b0;
      reset     = 1'b0;
      reg_req   = 1'b0;
      reg_write = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      ext_a     = 1'b0;
      ext_b     = 1'b0;
      ext_i     = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      seed_val = $urandom(32'he8e911c5);

      apply_reset();
      start = errors;
      for (int off = 3; off <= 5; off++) begin
         wval = $urandom;
         write_reg(base + 8'(off), wval);
         read_reg(base + 8'(off), rdata);
         if (rdata !== wval) begin
            mismatch($sformatf("readback offset %0d", off), wval, rdata);
         end
      end
      bus_access(1'b0, base + 8'd9, 32'd0, rdata, acked);
      if (acked) begin
         report_error("address outside the register range was acknowledged");
      end
      test_done("register readback", start);

      // random walk with index pulses, first event is always a step
      events_q.delete();
      events_q.push_back(($urandom % 2) ? 1 : -1);
      n = 12 + $urandom % 20;
      for (int k = 0; k < n; k++) begin
         if ($urandom % 5 == 0) begin
            events_q.push_back(2);
         end else begin
            events_q.push_back(($urandom % 2) ? 1 : -1);
         end
      end
      for (int flip = 0; flip < 2; flip++) begin
         apply_reset();
         start = errors;
         write_reg(base + off_config, flip ? cfg_flip : 32'd0);
         play_events();
         read_reg(base + off_count, rdata);
         exp = flip ? -ref_count() : ref_count();
         if (rdata !== exp) begin
            mismatch($sformatf("count flip %0d", flip), exp, rdata);
         end
         read_reg(base + off_turns, rdata);
         exp = flip ? -ref_turns() : ref_turns();
         if (rdata !== exp) begin
            mismatch($sformatf("turns flip %0d", flip), exp, rdata);
         end
         test_done(flip ? "external count flipped" : "external count", start);
      end

      apply_reset();
      start = errors;
      for (int k = 0; k < 6; k++) begin
         lv = 3'($urandom % 8);
         write_reg(base + off_config, (k % 2) ? cfg_flip : 32'd0);
         @(posedge clk);
         ext_a <= lv[0];
         ext_b <= lv[1];
         ext_i <= lv[2];
         repeat (8) @(posedge clk);
         read_reg(base + off_status, rdata);
         if (k % 2) begin
            exp = {26'd0, lv[2], lv[0], lv[1], lv};
         end else begin
            exp = {26'd0, lv, lv};
         end
         if (rdata !== exp) begin
            mismatch($sformatf("status levels %03b flip %0d", lv, k % 2), exp, rdata);
         end
      end
      test_done("status", start);

      for (int ccw = 0; ccw < 2; ccw++) begin
         apply_reset();
         start = errors;
         write_reg(base + off_phase, 32'd3);
         write_reg(base + off_cpr, 32'd2);
         write_reg(base + off_config, cfg_source | cfg_sim_en | (ccw ? cfg_sim_ccw : 32'd0));
         repeat (150 + $urandom % 100) @(posedge clk);
         write_reg(base + off_config, cfg_source | (ccw ? cfg_sim_ccw : 32'd0));
         repeat (8) @(posedge clk);
         read_reg(base + off_count, count_a);
         read_reg(base + off_turns, rdata);
         sc = count_a;
         if (ccw == 0 && sc <= 0) begin
            report_error($sformatf("clockwise generator count %0d is not positive", sc));
         end
         if (ccw == 1 && sc >= 0) begin
            report_error($sformatf("counter-clockwise generator count %0d is not negative", sc));
         end
         // eight counts per revolution, truncated toward zero
         exp = sc / 8;
         if (rdata !== exp) begin
            mismatch("generator turns", exp, rdata);
         end
         read_reg(base + off_count, rdata);
         if (rdata !== count_a) begin
            mismatch("generator count held", count_a, rdata);
         end
         test_done(ccw ? "generator ccw" : "generator cw", start);
      end

      for (int t = 0; t < 3; t++) begin
         apply_reset();
         start = errors;
         fs = $urandom % 5;
         write_reg(base + off_config, cfg_speed | cfg_filter | (fs << 6));
         periods_q.delete();
         for (int k = 0; k < (1 << fs); k++) begin
            periods_q.push_back(4 + $urandom % 60);
            a_high_pulse(periods_q[k]);
         end
         poll_speed(rdata);
         exp = ref_speed(fs, speed_clamp);
         if (rdata !== exp) begin
            mismatch($sformatf("speed filter size %0d", fs), exp, rdata);
         end
         test_done($sformatf("speed set %0d", t), start);
      end

      // a long period stays below the clamp
      apply_reset();
      start = errors;
      write_reg(base + off_config, cfg_speed);
      periods_q.delete();
      periods_q.push_back(4000);
      a_high_pulse(4000);
      poll_speed(rdata);
      exp = ref_speed(0, speed_clamp);
      if (rdata !== exp) begin
         mismatch("speed long period", exp, rdata);
      end
      test_done("speed long period", start);

      $display("summary: %0d tests run, %0d failed, %0d errors",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: qe_channel.f
rtl/qe_reg_pkg.sv
rtl/qe_enc_pkg.sv
rtl/qe_event_if.sv
rtl/qe_reg_file.sv
rtl/qe_pattern_gen.sv
rtl/qe_input_select.sv
rtl/qe_decoder.sv
rtl/qe_position_counter.sv
rtl/qe_speed_measure.sv
rtl/qe_channel.sv
dv/qe_channel_tb.sv
